// ==== src/fifo_cfg_pkg.sv ====
// Fixed sizes of the FIFO, shared by every RTL block
// Depth is expected to be a power of two so the pointers wrap cleanly
// RAM read latency is fixed at one cycle, the pop side relies on it

package fifo_cfg_pkg;

  // Number of entries held, including the output register
  localparam int depth = 8;

  // Payload bits per entry
  localparam int data_width = 16;

  // RAM address bits
  localparam int addr_width = $clog2(depth);

  // Counter bits, must hold the value depth itself
  localparam int count_width = $clog2(depth + 1);

  // Cycles from read address to read data
  localparam int ram_rd_latency = 1;

endpackage : fifo_cfg_pkg

// ==== src/fifo_types_pkg.sv ====
// Bundled signals passed between the FIFO blocks
// Widths follow the fixed sizes of the configuration package

package fifo_types_pkg;

  import fifo_cfg_pkg::*;

  // One FIFO entry
  typedef struct packed {
    logic [data_width-1:0] data;
  } fifo_entry_t;

  // RAM write request, written at the next rising edge
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    fifo_entry_t           entry;
  } ram_wr_req_t;

  // RAM read request
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
  } ram_rd_req_t;

  // RAM read response, ram_rd_latency cycles after the request
  typedef struct packed {
    logic        valid;
    fifo_entry_t entry;
  } ram_rd_rsp_t;

  // Status seen at the top level
  typedef struct packed {
    logic [count_width-1:0] items;
    logic                   empty;
    logic                   full;
  } fifo_status_t;

endpackage : fifo_types_pkg

// ==== src/fifo_ram.sv ====
`timescale 1ns/1ns

// Flop array storage with one write port and one read port
// Read data is registered, one cycle after the request
// A read of the address written in the same cycle returns the old entry

module fifo_ram (
  input  logic                        clk,
  input  logic                        rst_n,
  input  fifo_types_pkg::ram_wr_req_t wr,
  input  fifo_types_pkg::ram_rd_req_t rd,
  output fifo_types_pkg::ram_rd_rsp_t rsp
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  fifo_entry_t mem [depth];
  fifo_entry_t rd_entry;
  logic        rd_valid;

  // Storage and read data
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.entry;
    end
    if (rd.valid) begin
      rd_entry <= mem[rd.addr];
    end
  end

  // Read data valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd.valid;
    end
  end

  assign rsp = '{valid: rd_valid, entry: rd_entry};

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  addr_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
    (wr.valid |-> wr.addr < depth) and (rd.valid |-> rd.addr < depth))
    else $error("RAM address out of range");

endmodule : fifo_ram

// ==== src/fifo_push_ctrl.sv ====
`timescale 1ns/1ns

// Push side of the FIFO with a free-slot counter and the write pointer
// Slots return only on pop beats, so an entry in flight still holds its slot
// A beat is routed to the bypass whenever the pop side raises bypass_ready

module fifo_push_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  // Push interface
  input  logic                        push_valid,
  input  fifo_types_pkg::fifo_entry_t push_data,
  output logic                        push_ready,
  // Bypass towards the pop side
  input  logic                        bypass_ready,
  output fifo_types_pkg::fifo_entry_t bypass_entry,
  // RAM write port
  output fifo_types_pkg::ram_wr_req_t ram_wr,
  // Handshakes between controllers
  output logic                        push_beat,
  input  logic                        pop_beat,
  // Status
  output logic                        full
);

  import fifo_cfg_pkg::*;

  logic [count_width-1:0] slots;
  logic [count_width-1:0] slots_next;
  logic [addr_width-1:0]  wr_ptr;
  logic                   ram_write;

  // --------------------------------------------------
  // Handshake and routing
  // --------------------------------------------------

  // Ready depends on free space only
  assign push_ready = (slots != '0);
  assign push_beat  = push_valid && push_ready;

  // Bypass carries the push payload as is
  assign bypass_entry = push_data;

  // Everything the pop side cannot take now goes to the RAM
  assign ram_write = push_beat && !bypass_ready;
  assign ram_wr    = '{valid: ram_write, addr: wr_ptr, entry: push_data};

  // --------------------------------------------------
  // Free slots and full flag
  // --------------------------------------------------
  always_comb begin
    slots_next = slots;
    if (push_beat && !pop_beat) begin
      slots_next = slots - 1'b1;
    end else if (!push_beat && pop_beat) begin
      slots_next = slots + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= count_width'(depth);
      full  <= 1'b0;
    end else begin
      slots <= slots_next;
      full  <= (slots_next == '0);
    end
  end

  // Write pointer moves on RAM writes only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (ram_write) begin
      if (wr_ptr == addr_width'(depth - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // With every slot taken the pop side holds older entries and offers no bypass
  no_bypass_without_slots_a: assert property (@(posedge clk) disable iff (!rst_n)
    !push_ready |-> !bypass_ready)
    else $error("bypass offered with no free slot");

  slots_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
    slots <= count_width'(depth))
    else $error("free slots above depth");

endmodule : fifo_push_ctrl

// ==== src/fifo_pop_ctrl.sv ====
`timescale 1ns/1ns

// Pop side of the FIFO with item count, RAM reads and the output register
// Reads wait for a free output register, so RAM data flows at most every
// second cycle, while a push into an empty FIFO is visible after one cycle
// RAM read latency is assumed to be one cycle

module fifo_pop_ctrl (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Pop interface
  input  logic                                 pop_ready,
  output logic                                 pop_valid,
  output fifo_types_pkg::fifo_entry_t          pop_data,
  // Bypass from the push side
  output logic                                 bypass_ready,
  input  fifo_types_pkg::fifo_entry_t          bypass_entry,
  // Handshakes between controllers
  input  logic                                 push_beat,
  output logic                                 pop_beat,
  // RAM read port
  output fifo_types_pkg::ram_rd_req_t          ram_rd,
  input  fifo_types_pkg::ram_rd_rsp_t          ram_rd_rsp,
  // Status
  output logic [fifo_cfg_pkg::count_width-1:0] items,
  output logic                                 empty
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  logic [count_width-1:0] items_next;
  logic [count_width-1:0] ram_items;
  logic [addr_width-1:0]  rd_ptr;
  logic                   rd_pending;
  logic                   rd_issue;
  logic                   ram_write;
  logic                   out_free;
  logic                   out_load;
  fifo_entry_t            out_entry_next;

  // --------------------------------------------------
  // Flow control
  // --------------------------------------------------
  assign pop_beat = pop_valid && pop_ready;

  // Output register is empty or leaves this cycle
  assign out_free = !pop_valid || pop_beat;

  // Bypass only when nothing older sits in the RAM or in flight
  assign bypass_ready = (ram_items == '0) && !rd_pending && out_free;

  // Push beats not taken by the bypass land in the RAM
  assign ram_write = push_beat && !bypass_ready;

  // One read at a time, data returns into a free output register
  assign rd_issue = (ram_items != '0) && !rd_pending && out_free;
  assign ram_rd   = '{valid: rd_issue, addr: rd_ptr};

  // Entries stored in the RAM and not yet read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_items <= '0;
    end else if (ram_write && !rd_issue) begin
      ram_items <= ram_items + 1'b1;
    end else if (!ram_write && rd_issue) begin
      ram_items <= ram_items - 1'b1;
    end
  end

  // Read pointer and the read in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr     <= '0;
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= rd_issue;
      if (rd_issue) begin
        if (rd_ptr == addr_width'(depth - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // Read data and bypass never arrive together
  assign out_load       = ram_rd_rsp.valid || (push_beat && bypass_ready);
  assign out_entry_next = ram_rd_rsp.valid ? ram_rd_rsp.entry : bypass_entry;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else if (out_load) begin
      pop_valid <= 1'b1;
    end else if (pop_beat) begin
      pop_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      pop_data <= out_entry_next;
    end
  end

  // --------------------------------------------------
  // Items and empty
  // --------------------------------------------------
  always_comb begin
    items_next = items;
    if (push_beat && !pop_beat) begin
      items_next = items + 1'b1;
    end else if (!push_beat && pop_beat) begin
      items_next = items - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else begin
      items <= items_next;
      empty <= (items_next == '0);
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  ram_rd_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    ram_rd.valid |-> ##ram_rd_latency ram_rd_rsp.valid)
    else $error("RAM read data late or missing");

  items_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
    items <= count_width'(depth))
    else $error("items above depth");

  // Push side slot count must agree with the item count
  no_push_when_all_items_a: assert property (@(posedge clk) disable iff (!rst_n)
    items == count_width'(depth) |-> !push_beat)
    else $error("push beat with FIFO holding depth items");

  pop_data_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else $error("pop data changed while stalled");

endmodule : fifo_pop_ctrl

// ==== src/fifo_top.sv ====
`timescale 1ns/1ns

// Synchronous FIFO with valid/ready on both sides
// No registers at this level, latencies are those of the controllers

module fifo_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // Push interface
  input  logic                         push_valid,
  input  fifo_types_pkg::fifo_entry_t  push_data,
  output logic                         push_ready,
  // Pop interface
  output logic                         pop_valid,
  output fifo_types_pkg::fifo_entry_t  pop_data,
  input  logic                         pop_ready,
  // Status
  output fifo_types_pkg::fifo_status_t status
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  logic                   push_beat;
  logic                   pop_beat;
  logic                   bypass_ready;
  fifo_entry_t            bypass_entry;
  ram_wr_req_t            ram_wr;
  ram_rd_req_t            ram_rd;
  ram_rd_rsp_t            ram_rd_rsp;
  logic [count_width-1:0] items;
  logic                   empty;
  logic                   full;

  // Push side
  fifo_push_ctrl u_push_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .bypass_ready (bypass_ready),
    .bypass_entry (bypass_entry),
    .ram_wr       (ram_wr),
    .push_beat    (push_beat),
    .pop_beat     (pop_beat),
    .full         (full)
  );

  // Pop side
  fifo_pop_ctrl u_pop_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .bypass_ready (bypass_ready),
    .bypass_entry (bypass_entry),
    .push_beat    (push_beat),
    .pop_beat     (pop_beat),
    .ram_rd       (ram_rd),
    .ram_rd_rsp   (ram_rd_rsp),
    .items        (items),
    .empty        (empty)
  );

  // Entry storage
  fifo_ram u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (ram_wr),
    .rd    (ram_rd),
    .rsp   (ram_rd_rsp)
  );

  // Items and empty from the pop side, full from the push side
  assign status = '{items: items, empty: empty, full: full};

endmodule : fifo_top

// ==== verif/fifo_clk_gen.sv ====
`timescale 1ns/1ns

// Clock and reset for the FIFO testbench, 4 ns period
// rst_n is released on a falling edge, away from the sampling edge

module fifo_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int period_ns    = 4;
  localparam int reset_cycles = 3;

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Reset held for three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : fifo_clk_gen

// ==== verif/fifo_tb.sv ====
`timescale 1ns/1ns

// Testbench for fifo_top with a queue model checked on every rising edge
// Inputs change on falling edges and push data is the running push count

module fifo_tb;

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  // Phase lengths in cycles
  localparam int directed_cycles = 12 * depth + 60;
  localparam int bp_cycles       = 200;
  localparam int phase_cycles    = 300;
  localparam int stim_cycles     = 3 + directed_cycles + bp_cycles + 3 * phase_cycles;
  localparam int cycle_limit     = 2 * stim_cycles + 100;

  logic         clk;
  logic         rst_n;
  logic         push_valid;
  fifo_entry_t  push_data;
  logic         push_ready;
  logic         pop_valid;
  fifo_entry_t  pop_data;
  logic         pop_ready;
  fifo_status_t status;

  // Model state
  fifo_entry_t  model_q[$];
  int           model_count;
  int           pushed_total;
  int           bypass_due;
  logic         stall_prev;
  fifo_entry_t  held_data;

  int           seed;
  int           cycles;
  int           value_errors;
  int           other_errors;
  int           fill_start;

  fifo_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  fifo_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_ready  (pop_ready),
    .status     (status)
  );

  // --------------------------------------------------
  // Reference and compare tasks
  // --------------------------------------------------

  // Status implied by the number of entries held
  function automatic fifo_status_t expect_status(input int count);
    fifo_status_t st;
    st.items = count_width'(count);
    st.empty = (count == 0);
    st.full  = (count == depth);
    return st;
  endfunction

  // Oldest entry not yet popped
  function automatic fifo_entry_t expect_head();
    return model_q[0];
  endfunction

  function automatic logic chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // Readable form of a status word
  function automatic string status_text(input fifo_status_t st);
    return $sformatf("items=%0d empty=%0b full=%0b", st.items, st.empty, st.full);
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t ns: %s got %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic check_entry(input string name, input fifo_entry_t got, input fifo_entry_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t ns: %s got %h, expected %h", $time, name, got.data, exp.data);
    end
  endtask

  task automatic check_status(input fifo_status_t got, input fifo_status_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t ns: status got %s, expected %s",
               $time, status_text(got), status_text(exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      value_errors++;
      $display("Fail at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
  endtask

  // --------------------------------------------------
  // Model and compare on the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    logic push_hit;
    logic pop_hit;
    push_hit = push_valid && push_ready;
    pop_hit  = pop_valid && pop_ready;
    if (rst_n) begin
      // Outputs reflect beats up to the previous edge
      check_status(status, expect_status(model_count));
      check_bit("push_ready", push_ready, model_count != depth);
      if (bypass_due) begin
        check_bit("pop_valid after bypass push", pop_valid, 1'b1);
      end
      if (stall_prev) begin
        check_entry("pop_data while stalled", pop_data, held_data);
      end
      if (pop_valid && model_q.size() == 0) begin
        other_errors++;
        $display("Error at %0t ns: pop_valid is high while the model holds nothing", $time);
      end else if (pop_valid) begin
        check_entry("pop_data", pop_data, expect_head());
      end
      bypass_due = push_hit && (model_count == 0);
      stall_prev = pop_valid && !pop_ready;
      held_data  = pop_data;
      // Apply this edge's beats
      if (pop_hit && model_q.size() != 0) begin
        void'(model_q.pop_front());
        model_count--;
      end
      if (push_hit) begin
        model_q.push_back(push_data);
        model_count++;
        pushed_total++;
      end
    end
  end

  // Sequential payload that steps after each accepted push
  always @(negedge clk) begin
    push_data = fifo_entry_t'(data_width'(pushed_total));
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      other_errors++;
      $display("Timeout: run stopped after %0d cycles with %0d entries left", cycles, model_count);
      report_counts();
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic run_traffic(input int n, input int push_pct, input int pop_pct);
    repeat (n) begin
      @(negedge clk);
      push_valid = chance(push_pct);
      pop_ready  = chance(pop_pct);
    end
  endtask

  // Stop pushing and pop until the model is empty
  task automatic drain();
    @(negedge clk);
    push_valid = 1'b0;
    pop_ready  = 1'b1;
    while (model_count != 0) @(negedge clk);
    @(negedge clk);
    check_status(status, expect_status(0));
    check_bit("pop_valid after drain", pop_valid, 1'b0);
    check_bit("push_ready after drain", push_ready, 1'b1);
  endtask

  initial begin
    push_valid   = 1'b0;
    pop_ready    = 1'b0;
    push_data    = '0;
    model_count  = 0;
    pushed_total = 0;
    bypass_due   = 0;
    stall_prev   = 1'b0;
    held_data    = '0;
    seed         = 42013;
    cycles       = 0;
    value_errors = 0;
    other_errors = 0;

    // Values right after reset
    @(posedge rst_n);
    @(negedge clk);
    check_bit("push_ready after reset", push_ready, 1'b1);
    check_bit("pop_valid after reset", pop_valid, 1'b0);
    check_status(status, expect_status(0));

    // Single push through the bypass
    pop_ready  = 1'b1;
    push_valid = 1'b1;
    fill_start = pushed_total;
    while (pushed_total == fill_start) @(negedge clk);
    push_valid = 1'b0;
    drain();

    // Burst through the RAM
    fill_start = pushed_total;
    push_valid = 1'b1;
    while (pushed_total < fill_start + 2 * depth) @(negedge clk);
    drain();

    // Fill with the pop side stalled
    fill_start = pushed_total;
    pop_ready  = 1'b0;
    push_valid = 1'b1;
    repeat (depth + 4) @(negedge clk);
    check_count("entries accepted while filling", pushed_total - fill_start, depth);
    check_status(status, expect_status(depth));
    check_bit("push_ready when full", push_ready, 1'b0);

    // Back-pressure from full and then random traffic with shifting duty
    run_traffic(bp_cycles, 50, 25);
    run_traffic(phase_cycles, 70, 30);
    run_traffic(phase_cycles, 30, 70);
    run_traffic(phase_cycles, 50, 50);
    drain();

    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : fifo_tb

// ==== src.f ====
src/fifo_cfg_pkg.sv
src/fifo_types_pkg.sv
src/fifo_ram.sv
src/fifo_push_ctrl.sv
src/fifo_pop_ctrl.sv
src/fifo_top.sv
verif/fifo_clk_gen.sv
verif/fifo_tb.sv
